/* sim.f */
+incdir+src
src/narrator_pkg.sv
src/sample_rate_gen.sv
src/sample_player.sv
src/level_meter.sv
src/narrator_top.sv
bench/flash_model.sv
bench/narrator_props.sv
bench/narrator_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the narrator testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f sim.f --top-module narrator_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vnarrator_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF '*** TEST FAILED ***' "$LOG"; then
  exit 1
fi
exit 0

/* bench/narrator_tb.sv */
`timescale 1ns/100ps
`include "narrator_config.svh"

module narrator_tb;
  import narrator_pkg::*;

  localparam int SAMPLES = 4 * `NARR_WORDS_PER_PHONEME;   // Per phoneme

  logic       CLK_50M;
  logic       arst_n;
  logic       speed_up;
  logic       speed_down;
  logic       speed_reset;
  phoneme_t   phoneme;
  logic       start;
  flash_req_t flash_req;
  flash_rsp_t flash_rsp;
  sample_t    sample;
  logic       sample_valid;
  logic       busy;
  logic       done;
  led_bar_t   led_bar;
  divisor_t   divisor;

  int    errors = 0;
  int    checks = 0;
  int    tests_run = 0;
  int    test_errors = 0;
  string test_name = "none";
  bit    reported = 1'b0;

  // ====================
  // Output capture
  // ====================
  sample_t got[$];
  int      cycle_no = 0;
  int      read_cycles = 0;
  int      done_cnt = 0;
  int      done_cycle = 0;
  logic    busy_at_done = 1'b0;
  int      last_valid = 0;
  int      min_gap = 0;

  narrator_top UUT (.*);
  flash_model flash (.*);

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // Outputs sampled mid-cycle between clock edges
  always @(negedge CLK_50M)
  begin
    cycle_no++;
    if (flash_req.read)
      read_cycles++;
    if (sample_valid)
    begin
      if (got.size() > 0 && cycle_no - last_valid < min_gap)
        min_gap = cycle_no - last_valid;
      got.push_back(sample);
      last_valid = cycle_no;
    end
    if (done)
    begin
      done_cnt++;
      done_cycle   = cycle_no;
      busy_at_done = busy;
    end
  end

  // ====================
  // Helpers
  // ====================
  task automatic check_value(input string what, input integer expected, input integer actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      test_errors++;
      $display("** Error in %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
    end
  endtask

  task automatic finish_run();
    if (!reported)
    begin
      reported = 1'b1;
      $display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0)
        $display("*** TEST PASSED ***");
      else
        $display("*** TEST FAILED ***");
      $finish;
    end
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
    tests_run++;
  endtask

  task automatic end_test();
    $display("%-16s %s", test_name, (test_errors == 0) ? "ok" : "with errors");
  endtask

  task automatic strobe_speed(input logic up, input logic down, input logic rst);
    speed_up    = up;
    speed_down  = down;
    speed_reset = rst;
    @(posedge CLK_50M);
    #2;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
  endtask

  // Sample i of phoneme p is byte i%4 of word p*span + i/4
  function automatic sample_t exp_sample(input int p, input int i);
    int a;
    a = p * `NARR_PHONEME_SPAN + i / 4;
    if (p == 0)
      return '0;
    return sample_t'(4 * a + i % 4 + 1);
  endfunction

  // Bar after one window made of the phoneme's samples
  function automatic led_bar_t exp_bar(input int p);
    int sum;
    int level;
    int s;
    sum = 0;
    for (int i = 0; i < `NARR_METER_WINDOW; i++)
    begin
      s = int'(exp_sample(p, i));
      sum += (s < 0) ? -s : s;
    end
    level = sum / `NARR_METER_WINDOW / 16;
    if (level > 8)
      level = 8;
    return led_bar_t'((1 << level) - 1);
  endfunction

  // Plays one phoneme with an optional second start in the middle
  task automatic run_phoneme(input int p, input bit inject);
    int  limit;
    bit  injected;
    limit    = (SAMPLES + 1) * (int'(divisor) + 40) + `NARR_DIV_MAX;
    injected = 1'b0;
    got.delete();
    read_cycles  = 0;
    done_cnt     = 0;
    busy_at_done = 1'b1;
    min_gap      = 1 << 30;
    phoneme = phoneme_t'(p);
    start   = 1'b1;
    @(posedge CLK_50M);
    #2;
    start = 1'b0;
    check_value("busy after start", 1, 32'(busy));
    for (int n = 0; n < limit && done_cnt == 0; n++)
    begin
      @(posedge CLK_50M);
      #2;
      start = 1'b0;
      if (inject && !injected && got.size() == 5)
      begin
        phoneme  = phoneme_t'(p + 3);
        start    = 1'b1;
        injected = 1'b1;
      end
    end
    if (done_cnt == 0)
    begin
      $display("Timeout in %s: phoneme %0d never signalled done", test_name, p);
      errors++;
      finish_run();
    end
    else
    begin
      check_value("sample count", SAMPLES, got.size());
      for (int i = 0; i < got.size() && i < SAMPLES; i++)
        check_value($sformatf("sample %0d", i), 32'(exp_sample(p, i)), 32'(got[i]));
      check_value("done after last sample", last_valid + 1, done_cycle);
      check_value("busy at done", 0, 32'(busy_at_done));
      repeat (4)
      begin
        @(posedge CLK_50M);
        #2;
      end
      check_value("done pulses", 1, done_cnt);
      check_value("busy after done", 0, 32'(busy));
    end
  endtask

  // ====================
  // Tests
  // ====================
  task automatic test_reset();
    begin_test("reset state");
    check_value("divisor", `NARR_DIV_DEFAULT, 32'(divisor));
    check_value("led bar", 0, 32'(led_bar));
    check_value("busy", 0, 32'(busy));
    check_value("flash read", 0, 32'(flash_req.read));
    end_test();
  endtask

  task automatic test_speed();
    begin_test("speed control");
    repeat (3) strobe_speed(1'b1, 1'b0, 1'b0);
    check_value("divisor after 3 up", `NARR_DIV_DEFAULT - 3 * `NARR_DIV_STEP, 32'(divisor));
    repeat (50) strobe_speed(1'b0, 1'b1, 1'b0);
    check_value("divisor at max", `NARR_DIV_MAX, 32'(divisor));
    strobe_speed(1'b1, 1'b0, 1'b1);   // Reset beats up
    check_value("divisor restored", `NARR_DIV_DEFAULT, 32'(divisor));
    end_test();
  endtask

  task automatic test_playback();
    begin_test("playback");
    repeat (33) strobe_speed(1'b1, 1'b0, 1'b0);
    check_value("divisor at min", `NARR_DIV_MIN, 32'(divisor));
    run_phoneme(3, 1'b0);
    check_value("led bar", 32'(exp_bar(3)), 32'(led_bar));
    end_test();
  endtask

  task automatic test_spacing();
    int exp_div;
    exp_div = `NARR_DIV_MIN + `NARR_DIV_STEP;   // One step down from the minimum
    begin_test("sample spacing");
    strobe_speed(1'b0, 1'b1, 1'b0);
    check_value("divisor", exp_div, 32'(divisor));
    run_phoneme(1, 1'b0);
    check_value("shortest gap", exp_div, (min_gap < exp_div) ? min_gap : exp_div);
    end_test();
  endtask

  task automatic test_silence();
    begin_test("silence");
    run_phoneme(0, 1'b0);
    check_value("flash read cycles", 0, read_cycles);
    check_value("led bar", 0, 32'(led_bar));
    end_test();
  endtask

  task automatic test_meter();
    begin_test("level meter");
    run_phoneme(2, 1'b1);   // Loud phoneme with an ignored second start
    check_value("led bar", 32'(exp_bar(2)), 32'(led_bar));
    end_test();
  endtask

  initial
  begin
    arst_n      = 1'b0;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    phoneme     = '0;
    start       = 1'b0;
    repeat (8) @(posedge CLK_50M);
    #2;
    arst_n = 1'b1;
    test_reset();
    test_speed();
    test_playback();
    test_spacing();
    test_silence();
    test_meter();
    finish_run();
  end

  // Run stopped without the normal report
  final
    if (!reported)
      $display("*** TEST FAILED ***");

endmodule

/* bench/narrator_props.sv */
`timescale 1ns/100ps

module narrator_props (
  input logic                     CLK_50M,
  input logic                     arst_n,
  input narrator_pkg::flash_req_t flash_req,
  input narrator_pkg::flash_rsp_t flash_rsp,
  input logic                     sample_valid,
  input logic                     busy,
  input logic                     done
);

  // Read and address held until the flash takes the request
  a_read_hold: assert property (
    @(posedge CLK_50M) disable iff (!arst_n)
    (flash_req.read && flash_rsp.waitrequest)
      |=> (flash_req.read && flash_req.address == $past(flash_req.address))
  ) else $error("Flash read dropped or address moved during waitrequest");

  a_valid_busy: assert property (
    @(posedge CLK_50M) disable iff (!arst_n)
    sample_valid |-> busy
  ) else $error("Sample strobe outside of a busy phase");

  a_done_apart: assert property (
    @(posedge CLK_50M) disable iff (!arst_n)
    !(done && sample_valid)
  ) else $error("Done and sample strobe in the same cycle");

endmodule

bind sample_player narrator_props player_props (
  .CLK_50M      (CLK_50M),
  .arst_n       (arst_n),
  .flash_req    (flash_req),
  .flash_rsp    (flash_rsp),
  .sample_valid (sample_valid),
  .busy         (busy),
  .done         (done)
);

/* bench/flash_model.sv */
`timescale 1ns/100ps

module flash_model (
  input  logic                     CLK_50M,
  input  logic                     arst_n,
  input  narrator_pkg::flash_req_t flash_req,
  output narrator_pkg::flash_rsp_t flash_rsp
);
  import narrator_pkg::*;

  integer     seed = 81510;
  integer     rnd;
  logic       pending;     // One read in flight
  int         lat_cnt;     // Cycles left until data
  word_addr_t pend_addr;

  // Byte k of word a holds 4a + k + 1
  function automatic flash_word_t word_at(input word_addr_t a);
    flash_word_t w;
    for (int k = 0; k < 4; k++)
      w[8*k +: 8] = 8'(4 * int'(a) + k + 1);
    return w;
  endfunction

  always @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      flash_rsp.waitrequest   <= 1'b1;
      flash_rsp.readdatavalid <= 1'b0;
      flash_rsp.readdata      <= '0;
      pending                 <= 1'b0;
      lat_cnt                 <= 0;
      pend_addr               <= '0;
    end
    else
    begin
      rnd = $random(seed);
      flash_rsp.waitrequest   <= rnd[0];   // Random stall, about half the cycles
      flash_rsp.readdatavalid <= 1'b0;
      flash_rsp.readdata      <= '0;
      if (flash_req.read && !flash_rsp.waitrequest)
      begin
        pending   <= 1'b1;
        pend_addr <= flash_req.address;
        lat_cnt   <= 2 + int'(rnd[15:8] % 8'd3);   // 2 to 4 cycles
      end
      else if (pending)
      begin
        if (lat_cnt == 1)
        begin
          flash_rsp.readdatavalid <= 1'b1;
          flash_rsp.readdata      <= word_at(pend_addr);
          pending                 <= 1'b0;
        end
        else
          lat_cnt <= lat_cnt - 1;
      end
    end
  end

endmodule

/* src/narrator_top.sv */
`timescale 1ns/100ps

module narrator_top (
  input  logic                     CLK_50M,
  input  logic                     arst_n,
  input  logic                     speed_up,
  input  logic                     speed_down,
  input  logic                     speed_reset,
  input  narrator_pkg::phoneme_t   phoneme,
  input  logic                     start,
  output narrator_pkg::flash_req_t flash_req,
  input  narrator_pkg::flash_rsp_t flash_rsp,
  output narrator_pkg::sample_t    sample,
  output logic                     sample_valid,
  output logic                     busy,
  output logic                     done,
  output narrator_pkg::led_bar_t   led_bar,
  output narrator_pkg::divisor_t   divisor
);
  import narrator_pkg::*;

  logic tick;   // Sample rate strobe

  sample_rate_gen rate_gen (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .divisor     (divisor),      // Shown where the 7-seg used to be
    .tick        (tick)
  );

  sample_player player (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .phoneme      (phoneme),
    .start        (start),
    .tick         (tick),
    .flash_req    (flash_req),
    .flash_rsp    (flash_rsp),   // Only flash master
    .sample       (sample),
    .sample_valid (sample_valid),
    .busy         (busy),
    .done         (done)
  );

  level_meter meter (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .sample       (sample),
    .sample_valid (sample_valid),
    .led_bar      (led_bar)
  );

endmodule

/* src/level_meter.sv */
`timescale 1ns/100ps
`include "narrator_config.svh"

module level_meter (
  input  logic                   CLK_50M,
  input  logic                   arst_n,
  input  narrator_pkg::sample_t  sample,
  input  logic                   sample_valid,
  output narrator_pkg::led_bar_t led_bar
);
  import narrator_pkg::*;

  localparam int WINDOW   = `NARR_METER_WINDOW;
  localparam int CNT_W    = $clog2(WINDOW + 1);
  localparam int ACC_W    = 9 + CNT_W;   // 9-bit magnitude times window
  localparam int BAR_W    = $bits(led_bar_t);
  localparam int BAR_STEP = 16;          // Mean per lit LED

  logic [8:0]       mag;       // -128 gives 128
  logic [CNT_W-1:0] win_cnt;
  logic [ACC_W-1:0] acc;
  logic [ACC_W-1:0] total;
  logic [ACC_W-1:0] mean;
  logic [ACC_W-1:0] level;
  led_bar_t         bar_next;

  // ====================
  // Magnitude and bar
  // ====================
  always_comb
  begin
    if (sample[7])
      mag = ~{sample[7], sample} + 9'd1;
    else
      mag = {1'b0, sample};

    total = acc + ACC_W'(mag);
    mean  = total / ACC_W'(WINDOW);
    level = mean / ACC_W'(BAR_STEP);

    // Thermometer code, saturates when level passes the width
    for (int i = 0; i < BAR_W; i++)
      bar_next[i] = (ACC_W'(i) < level);
  end

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      win_cnt <= '0;
      acc     <= '0;
      led_bar <= '0;
    end
    else if (sample_valid)
    begin
      if (win_cnt == CNT_W'(WINDOW - 1))
      begin
        win_cnt <= '0;
        acc     <= '0;         // Window closed, start over
        led_bar <= bar_next;
      end
      else
      begin
        win_cnt <= win_cnt + 1'b1;
        acc     <= total;
      end
    end
  end

endmodule

/* src/sample_player.sv */
`timescale 1ns/100ps
`include "narrator_config.svh"

module sample_player (
  input  logic                     CLK_50M,
  input  logic                     arst_n,
  input  narrator_pkg::phoneme_t   phoneme,
  input  logic                     start,
  input  logic                     tick,
  output narrator_pkg::flash_req_t flash_req,
  input  narrator_pkg::flash_rsp_t flash_rsp,
  output narrator_pkg::sample_t    sample,
  output logic                     sample_valid,
  output logic                     busy,
  output logic                     done
);
  import narrator_pkg::*;

  localparam int WORDS  = `NARR_WORDS_PER_PHONEME;
  localparam int WCNT_W = $clog2(WORDS + 1);

  localparam word_addr_t PHONEME_SPAN = word_addr_t'(`NARR_PHONEME_SPAN);
  localparam logic [WCNT_W-1:0] LAST_WORD = WCNT_W'(WORDS - 1);

  player_state_t     state;
  word_addr_t        word_addr;   // Address of the current word
  logic [WCNT_W-1:0] word_cnt;    // Words done in this phoneme
  logic [1:0]        byte_idx;    // Next byte of the word
  logic              silent;      // Phoneme 0, no flash traffic
  flash_word_t       word_buf;

  logic accept_start;
  logic emit;
  logic last_byte;
  logic last_word;

  assign accept_start = (state == st_idle) && start && !busy;
  assign emit         = (state == st_play) && tick;
  assign last_byte    = (byte_idx == 2'd3);
  assign last_word    = (word_cnt == LAST_WORD);

  // Read is a level straight from the FSM
  always_comb
  begin
    flash_req.read    = (state == st_request);
    flash_req.address = word_addr;
  end

  // ====================
  // Control FSM
  // ====================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state        <= st_idle;
      word_addr    <= '0;
      word_cnt     <= '0;
      byte_idx     <= '0;
      silent       <= 1'b0;
      busy         <= 1'b0;
      done         <= 1'b0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= 1'b0;   // Single-cycle strobes
      done         <= 1'b0;

      case (state)
        st_idle:
        begin
          if (accept_start)
          begin
            word_addr <= word_addr_t'(phoneme) * PHONEME_SPAN;
            word_cnt  <= '0;
            byte_idx  <= '0;
            silent    <= (phoneme == '0);
            busy      <= 1'b1;
            // Silence goes straight to playing zeros
            state     <= (phoneme == '0) ? st_play : st_request;
          end
        end

        st_request:
        begin
          if (!flash_rsp.waitrequest)
            state <= st_await_data;   // Accepted this cycle
        end

        st_await_data:
        begin
          if (flash_rsp.readdatavalid)
            state <= st_play;
        end

        st_play:
        begin
          if (emit)
          begin
            sample_valid <= 1'b1;
            byte_idx     <= byte_idx + 1'b1;
            if (last_byte)
            begin
              if (last_word)
                state <= st_finish;
              else
              begin
                word_cnt  <= word_cnt + 1'b1;
                word_addr <= word_addr + 1'b1;
                state     <= silent ? st_play : st_request;
              end
            end
          end
        end

        st_finish:
        begin
          // One cycle after the last sample
          done  <= 1'b1;
          busy  <= 1'b0;
          state <= st_idle;
        end

        default: state <= st_idle;
      endcase
    end
  end

  // ====================
  // Word and sample data
  // ====================
  always_ff @(posedge CLK_50M)
  begin
    if (accept_start)
      word_buf <= '0;   // Silent words stay at zero
    else if (state == st_await_data && flash_rsp.readdatavalid)
      word_buf <= flash_rsp.readdata;

    if (emit)
      sample <= word_buf[{byte_idx, 3'b000} +: 8];   // LSB first
  end

endmodule

/* src/sample_rate_gen.sv */
`timescale 1ns/100ps
`include "narrator_config.svh"

module sample_rate_gen (
  input  logic                   CLK_50M,
  input  logic                   arst_n,
  input  logic                   speed_up,
  input  logic                   speed_down,
  input  logic                   speed_reset,
  output narrator_pkg::divisor_t divisor,
  output logic                   tick
);
  import narrator_pkg::*;

  localparam divisor_t DIV_DEFAULT = divisor_t'(`NARR_DIV_DEFAULT);
  localparam divisor_t DIV_STEP    = divisor_t'(`NARR_DIV_STEP);
  localparam divisor_t DIV_MIN     = divisor_t'(`NARR_DIV_MIN);
  localparam divisor_t DIV_MAX     = divisor_t'(`NARR_DIV_MAX);

  divisor_t tick_cnt;   // Counts down to the next tick

  // ====================
  // Divisor register
  // ====================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      divisor <= DIV_DEFAULT;
    else if (speed_reset)
      divisor <= DIV_DEFAULT;   // Reset wins over up and down
    else if (speed_up)
    begin
      // Smaller divisor means faster playback
      if (divisor <= DIV_MIN + DIV_STEP)
        divisor <= DIV_MIN;
      else
        divisor <= divisor - DIV_STEP;
    end
    else if (speed_down)
    begin
      if (divisor >= DIV_MAX - DIV_STEP)
        divisor <= DIV_MAX;
      else
        divisor <= divisor + DIV_STEP;
    end
  end

  // ====================
  // Tick generator
  // ====================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      tick_cnt <= DIV_DEFAULT - 1'b1;
      tick     <= 1'b0;
    end
    else if (tick_cnt == '0)
    begin
      tick_cnt <= divisor - 1'b1;   // Reload picks up a new divisor
      tick     <= 1'b1;
    end
    else
    begin
      tick_cnt <= tick_cnt - 1'b1;
      tick     <= 1'b0;
    end
  end

endmodule

/* src/narrator_pkg.sv */
package narrator_pkg;

  // Vectors with a meaning of their own
  typedef logic signed [7:0] sample_t;
  typedef logic [31:0]       flash_word_t;
  typedef logic [22:0]       word_addr_t;
  typedef logic [15:0]       divisor_t;
  typedef logic [7:0]        phoneme_t;
  typedef logic [7:0]        led_bar_t;

  // Flash master side, read only
  typedef struct packed {
    logic       read;
    word_addr_t address;
  } flash_req_t;

  // Flash slave side
  typedef struct packed {
    logic        waitrequest;
    logic        readdatavalid;
    flash_word_t readdata;
  } flash_rsp_t;

  // Player FSM
  typedef enum logic [2:0] {
    st_idle,
    st_request,      // Read held until accepted
    st_await_data,   // One read outstanding
    st_play,         // Four bytes out on ticks
    st_finish
  } player_state_t;

endpackage

/* src/narrator_config.svh */
`ifndef NARRATOR_CONFIG_SVH
`define NARRATOR_CONFIG_SVH

// ====================
// Sample clock divisor
// ====================

// Divisor out of reset, about 14.4 kHz at 50 MHz
`define NARR_DIV_DEFAULT 3472

// Change per speed strobe
`define NARR_DIV_STEP 100

// Clamp range for the divisor
`define NARR_DIV_MIN 200
`define NARR_DIV_MAX 8000

// ====================
// Flash layout
// ====================

`define NARR_WORDS_PER_PHONEME 4   // Words read per phoneme
`define NARR_PHONEME_SPAN 16       // Word distance between phoneme starts

// ====================
// LED meter
// ====================

`define NARR_METER_WINDOW 16       // Valid samples per averaging window

`endif
